/* all.f */
src/line_code_pkg.sv
src/link_tx_pkg.sv
src/tx_byte_intake.sv
src/enc_8b10b.sv
src/symbol_serializer.sv
src/serial_tx_top.sv
verif/tb_clk_gen.sv
verif/serial_tx_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it
verilator --binary --timing --top-module serial_tx_tb -f all.f -o serial_tx_sim \
	&& ./obj_dir/serial_tx_sim | tee /dev/stderr | grep -q "Finished with no errors" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* verif/serial_tx_tb.sv */
`timescale 1ns/1ps

module serial_tx_tb
	import line_code_pkg::*;
	import link_tx_pkg::*;
;

	logic  clk;
	logic  rst;
	logic  wr;
	logic  k;
	byte_t data;
	logic  full;
	logic  overrun;
	logic  k_err;
	logic  serial;
	logic  sym_start;

	int      errors;
	int      tests_failed;
	int      tests_run;
	int      n_started;    // symbols whose bit a has been seen
	symbol_t sym_log[$];   // every captured symbol
	rd_t     rd_log[$];    // tracked disparity before each symbol
	rd_t     trk_rd;
	logic    last_bit;
	int      run_len;
	integer  seed;

	tb_clk_gen tb_clk_gen_i (
		.o_CLK (clk),
		.o_rst (rst)
	);

	serial_tx_top serial_tx_top_i (
		.i_CLK       (clk),
		.i_rst       (rst),
		.i_wr        (wr),
		.i_k         (k),
		.i_data      (data),
		.o_full      (full),
		.o_overrun   (overrun),
		.o_k_err     (k_err),
		.o_serial    (serial),
		.o_sym_start (sym_start)
	);

	// code group written a first, as in the tables
	function automatic symbol_t wire_order(input logic [9:0] w);
		wire_order = {<<{w}};
	endfunction

	function automatic symbol_t comma_for(input rd_t rd);
		if (rd == RD_NEG)
			comma_for = wire_order(10'b0011111010);
		else
			comma_for = wire_order(10'b1100000101);
	endfunction

	task automatic timeout_abort(input string what);
		$display("timeout while waiting for %s", what);
		$display("Finished with errors");
		$finish;
	endtask

	task automatic check_sym(input string name, input symbol_t got, input symbol_t exp);
		if (got !== exp)
		begin
			$display("Error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_disparity(input symbol_t s, input rd_t rd);
		int ones;
		ones = $countones(s);
		if (ones < 4 || ones > 6 || (ones == 6 && rd != RD_NEG) || (ones == 4 && rd != RD_POS))
		begin
			$display("Error: o_serial symbol %h has %h ones at rd %h", s, ones, rd);
			errors++;
		end
	endtask

	task automatic track_run(input logic b);
		if (b === last_bit)
			run_len++;
		else
			run_len = 1;
		last_bit = b;
		if (run_len == 6)
		begin
			$display("serial line held one level for more than five bits");
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// symbol capture
	////////////////////////////////////////////////////////////////////////////

	task automatic capture_symbol(output symbol_t s);
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > 40)
				timeout_abort("o_sym_start");
		end
		while (sym_start !== 1'b1);
		n_started++;
		s[0] = serial;
		track_run(serial);
		for (int i = 1; i < 10; i++)
		begin
			@(negedge clk);
			s[i] = serial;
			track_run(serial);
		end
	endtask

	// every symbol on the line is logged and checked for disparity
	initial
	begin
		symbol_t s;
		@(negedge rst);
		forever
		begin
			capture_symbol(s);
			check_disparity(s, trk_rd);
			sym_log.push_back(s);
			rd_log.push_back(trk_rd);
			if ($countones(s) != 5)
				trk_rd = ~trk_rd;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic write_byte(input logic kf, input byte_t b);
		@(posedge clk);
		#5;
		wr   = 1'b1;
		k    = kf;
		data = b;
		@(posedge clk);
		#5;
		wr   = 1'b0;
		k    = 1'b0;
		data = 8'h00;
	endtask

	task automatic wait_symbols(input int count);
		int n;
		n = 0;
		while (sym_log.size() < count)
		begin
			@(negedge clk);
			n++;
			if (n > 40)
				timeout_abort("a captured symbol");
		end
	endtask

	// returns the index of the symbol that carries the held byte
	task automatic wait_taken(output int idx);
		int n;
		n = 0;
		while (full === 1'b1)
		begin
			@(negedge clk);
			n++;
			if (n > 40)
				timeout_abort("o_full to drop");
		end
		idx = n_started;
		wait_symbols(idx + 1);
	endtask

	task automatic wait_sym_start;
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > 40)
				timeout_abort("a symbol boundary");
		end
		while (sym_start !== 1'b1);
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors != err_before)
		begin
			tests_failed++;
			$display("test %s: failed", name);
		end
		else
			$display("test %s: passed", name);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_idle;
		int e0;
		int n;
		e0 = errors;
		n  = 0;
		while (n_started == 0)
		begin
			@(negedge clk);
			check_flag("o_serial", serial, 1'b0); // low until the first comma bits
			n++;
			if (n > 20)
				timeout_abort("the first symbol after reset");
		end
		for (int c = 0; c < 40; c++)
		begin
			@(negedge clk);
			check_flag("o_full", full, 1'b0);
			check_flag("o_overrun", overrun, 1'b0);
			check_flag("o_k_err", k_err, 1'b0);
		end
		wait_symbols(4);
		for (int i = 0; i < 4; i++)
			check_sym("o_serial", sym_log[i], comma_for(i % 2 == 0 ? RD_NEG : RD_POS));
		finish_test("idle", e0);
	endtask

	task automatic test_known_codes;
		int e0;
		int idx;
		e0 = errors;
		write_byte(1'b0, 8'hB5);
		check_flag("o_full", full, 1'b1);
		wait_taken(idx);
		check_sym("o_serial", sym_log[idx], wire_order(10'b1010101010));

		write_byte(1'b0, 8'h00);
		check_flag("o_full", full, 1'b1);
		wait_taken(idx);
		if (rd_log[idx] == RD_NEG)
			check_sym("o_serial", sym_log[idx], wire_order(10'b1001110100));
		else
			check_sym("o_serial", sym_log[idx], wire_order(10'b0110001011));

		write_byte(1'b1, K28_5_BYTE);
		check_flag("o_full", full, 1'b1);
		check_flag("o_k_err", k_err, 1'b0);
		wait_taken(idx);
		check_sym("o_serial", sym_log[idx], comma_for(rd_log[idx]));
		finish_test("known_codes", e0);
	endtask

	task automatic test_random_disparity;
		int    e0;
		int    idx;
		byte_t b;
		e0 = errors;
		for (int i = 0; i < 200; i++)
		begin
			b = 8'($random(seed));
			write_byte(1'b0, b);
			wait_taken(idx);
		end
		finish_test("random_disparity", e0);
	endtask

	task automatic test_illegal_k;
		int e0;
		int idx;
		e0 = errors;
		write_byte(1'b1, 8'h00);
		check_flag("o_k_err", k_err, 1'b1);
		@(posedge clk);
		#5;
		check_flag("o_k_err", k_err, 1'b0);
		wait_taken(idx);
		check_sym("o_serial", sym_log[idx], comma_for(rd_log[idx]));
		finish_test("illegal_k", e0);
	endtask

	task automatic test_overrun;
		int e0;
		int idx;
		e0 = errors;
		wait_sym_start; // both writes land well before the next request
		write_byte(1'b0, 8'hB5);
		check_flag("o_overrun", overrun, 1'b0);
		write_byte(1'b0, 8'h00);
		check_flag("o_overrun", overrun, 1'b1);
		check_flag("o_full", full, 1'b1);
		@(posedge clk);
		#5;
		check_flag("o_overrun", overrun, 1'b0);
		wait_taken(idx);
		check_sym("o_serial", sym_log[idx], wire_order(10'b1010101010));
		wait_symbols(idx + 2);
		check_sym("o_serial", sym_log[idx + 1], comma_for(rd_log[idx + 1]));
		finish_test("overrun", e0);
	endtask

	initial
	begin
		wr           = 1'b0;
		k            = 1'b0;
		data         = 8'h00;
		errors       = 0;
		tests_failed = 0;
		tests_run    = 0;
		n_started    = 0;
		trk_rd       = RD_NEG;
		last_bit     = 1'bx;
		run_len      = 0;
		seed         = 32'h90f4_085d;

		@(negedge rst);
		test_idle;
		test_known_codes;
		test_random_disparity;
		test_illegal_k;
		test_overrun;

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
(
	output logic o_CLK,
	output logic o_rst
);

	initial
	begin
		o_CLK = 1'b0;
		forever
			#50 o_CLK = ~o_CLK; // 100 ns period
	end

	initial
	begin
		o_rst = 1'b1;
		repeat (5) @(posedge o_CLK);
		#5 o_rst = 1'b0;
	end

endmodule

/* src/serial_tx_top.sv */
`timescale 1ns/1ps

module serial_tx_top
	import line_code_pkg::*;
	import link_tx_pkg::*;
#(
	parameter byte_t IDLE_K = K28_5_BYTE
)
(
	input  logic  i_CLK,
	input  logic  i_rst,
	input  logic  i_wr,
	input  logic  i_k,
	input  byte_t i_data,
	output logic  o_full,
	output logic  o_overrun,
	output logic  o_k_err,
	output logic  o_serial,
	output logic  o_sym_start
);

	tx_word_t word;
	symbol_t  sym;
	logic     req;  // serializer wants the next word
	logic     load; // word is valid, encode it

	tx_byte_intake #(
		.IDLE_K (IDLE_K)
	) tx_byte_intake_i (
		.i_CLK     (i_CLK),
		.i_rst     (i_rst),
		.i_wr      (i_wr),
		.i_k       (i_k),
		.i_data    (i_data),
		.i_req     (req),
		.o_word    (word),
		.o_full    (o_full),
		.o_overrun (o_overrun),
		.o_k_err   (o_k_err)
	);

	enc_8b10b enc_8b10b_i (
		.i_CLK  (i_CLK),
		.i_rst  (i_rst),
		.i_word (word),
		.i_load (load),
		.o_sym  (sym)
	);

	symbol_serializer symbol_serializer_i (
		.i_CLK       (i_CLK),
		.i_rst       (i_rst),
		.i_sym       (sym),
		.o_req       (req),
		.o_load      (load),
		.o_serial    (o_serial),
		.o_sym_start (o_sym_start)
	);

endmodule

/* src/symbol_serializer.sv */
`timescale 1ns/1ps

module symbol_serializer
	import line_code_pkg::*;
	import link_tx_pkg::*;
(
	input  logic    i_CLK,
	input  logic    i_rst,
	input  symbol_t i_sym,
	output logic    o_req,
	output logic    o_load,
	output logic    o_serial,
	output logic    o_sym_start
);

	localparam bit_cnt_t LAST_CNT = bit_cnt_t'(SYM_BITS - 1);
	localparam bit_cnt_t REQ_CNT  = LAST_CNT - 4'd2; // intake answers at 8
	localparam bit_cnt_t LOAD_CNT = LAST_CNT - 4'd1; // encoder answers at 9

	ser_state_e state;
	bit_cnt_t   bit_cnt;
	symbol_t    shift_q;

	////////////////////////////////////////////////////////////////////////////
	// bit counter and state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_CLK)
	begin
		if (i_rst)
		begin
			state   <= SER_RESET;
			bit_cnt <= '0;
		end
		else
		begin
			if (bit_cnt == LAST_CNT)
				bit_cnt <= '0;
			else
				bit_cnt <= bit_cnt + 4'd1;

			case (state)
				SER_RESET:
				begin
					if (bit_cnt == LAST_CNT)
						state <= SER_RUN; // first symbol goes into shift_q now
				end
				default:
					state <= SER_RUN;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge i_CLK)
	begin
		if (bit_cnt == LAST_CNT)
			shift_q <= i_sym;
		else
			shift_q <= shift_q >> 1;
	end

	assign o_req       = (bit_cnt == REQ_CNT);
	assign o_load      = (bit_cnt == LOAD_CNT);
	assign o_serial    = (state == SER_RUN) && shift_q[0];
	assign o_sym_start = (state == SER_RUN) && (bit_cnt == '0);

endmodule

/* src/enc_8b10b.sv */
`timescale 1ns/1ps

module enc_8b10b
	import line_code_pkg::*;
	import link_tx_pkg::*;
(
	input  logic     i_CLK,
	input  logic     i_rst,
	input  tx_word_t i_word,
	input  logic     i_load,
	output symbol_t  o_sym
);

	logic [4:0] x;         // EDCBA
	logic [2:0] y;         // HGF
	logic       k28;
	logic [5:0] code6_neg; // abcdei, a in the msb
	logic [5:0] code6;
	logic       unbal6;
	logic [3:0] code4_neg; // fghj, f in the msb
	logic [3:0] code4;
	logic       unbal4;
	logic       use_a7;
	rd_t        rd;
	rd_t        rd6;       // disparity between the sub-blocks
	rd_t        rd_next;

	assign x   = i_word.data[4:0];
	assign y   = i_word.data[7:5];
	assign k28 = i_word.k && (x == K28_0_BYTE[4:0]);

	////////////////////////////////////////////////////////////////////////////
	// 5b/6b sub-block
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (x) // RD- column
			5'd0:  code6_neg = 6'b100111;
			5'd1:  code6_neg = 6'b011101;
			5'd2:  code6_neg = 6'b101101;
			5'd3:  code6_neg = 6'b110001;
			5'd4:  code6_neg = 6'b110101;
			5'd5:  code6_neg = 6'b101001;
			5'd6:  code6_neg = 6'b011001;
			5'd7:  code6_neg = 6'b111000; // balanced but still alternates
			5'd8:  code6_neg = 6'b111001;
			5'd9:  code6_neg = 6'b100101;
			5'd10: code6_neg = 6'b010101;
			5'd11: code6_neg = 6'b110100;
			5'd12: code6_neg = 6'b001101;
			5'd13: code6_neg = 6'b101100;
			5'd14: code6_neg = 6'b011100;
			5'd15: code6_neg = 6'b010111;
			5'd16: code6_neg = 6'b011011;
			5'd17: code6_neg = 6'b100011;
			5'd18: code6_neg = 6'b010011;
			5'd19: code6_neg = 6'b110010;
			5'd20: code6_neg = 6'b001011;
			5'd21: code6_neg = 6'b101010;
			5'd22: code6_neg = 6'b011010;
			5'd23: code6_neg = 6'b111010;
			5'd24: code6_neg = 6'b110011;
			5'd25: code6_neg = 6'b100110;
			5'd26: code6_neg = 6'b010110;
			5'd27: code6_neg = 6'b110110;
			5'd28: code6_neg = 6'b001110;
			5'd29: code6_neg = 6'b101110;
			5'd30: code6_neg = 6'b011110;
			default: code6_neg = 6'b101011;
		endcase
		if (k28)
			code6_neg = 6'b001111; // K28 has its own 6b form

		unbal6 = ($countones(code6_neg) != 3);
		code6  = code6_neg;
		if (rd == RD_POS && (unbal6 || x == 5'd7))
			code6 = ~code6_neg;
		rd6 = rd ^ unbal6;
	end

	////////////////////////////////////////////////////////////////////////////
	// 3b/4b sub-block
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// A7 avoids a run of five across the 6b/4b boundary
		use_a7 = (y == 3'd7) &&
			(i_word.k ||
			(rd6 == RD_NEG && x inside {5'd17, 5'd18, 5'd20}) ||
			(rd6 == RD_POS && x inside {5'd11, 5'd13, 5'd14}));

		case (y)
			3'd0:    code4_neg = 4'b1011;
			3'd1:    code4_neg = 4'b1001;
			3'd2:    code4_neg = 4'b0101;
			3'd3:    code4_neg = 4'b1100;
			3'd4:    code4_neg = 4'b1101;
			3'd5:    code4_neg = 4'b1010;
			3'd6:    code4_neg = 4'b0110;
			default: code4_neg = 4'b1110; // primary x.7
		endcase
		if (use_a7)
			code4_neg = 4'b0111;

		unbal4 = ($countones(code4_neg) != 2);
		code4  = code4_neg;
		if (rd6 == RD_POS && (unbal4 || y == 3'd3))
			code4 = ~code4_neg;

		// control codes invert the balanced forms after a negative 6b block
		if (i_word.k && rd6 == RD_NEG && y inside {3'd1, 3'd2, 3'd5, 3'd6})
			code4 = ~code4_neg;

		rd_next = rd6 ^ unbal4;
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_rst)
			rd <= RD_NEG;
		else if (i_load)
			rd <= rd_next;
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_load)
			o_sym <= {<<{code6, code4}}; // a lands in bit 0
	end

endmodule

/* src/tx_byte_intake.sv */
`timescale 1ns/1ps

module tx_byte_intake
	import line_code_pkg::*;
	import link_tx_pkg::*;
#(
	parameter byte_t IDLE_K = K28_5_BYTE
)
(
	input  logic     i_CLK,
	input  logic     i_rst,
	input  logic     i_wr,
	input  logic     i_k,
	input  byte_t    i_data,
	input  logic     i_req,
	output tx_word_t o_word,
	output logic     o_full,
	output logic     o_overrun,
	output logic     o_k_err
);

	tx_word_t held;
	tx_word_t wr_word;
	logic     take;  // write goes into the holding register
	logic     bad_k;

	function automatic logic legal_k(input byte_t b);
		case (b)
			K28_0_BYTE, K28_1_BYTE, K28_2_BYTE, K28_3_BYTE,
			K28_4_BYTE, K28_5_BYTE, K28_6_BYTE, K28_7_BYTE,
			K23_7_BYTE, K27_7_BYTE, K29_7_BYTE, K30_7_BYTE:
				legal_k = 1'b1;
			default:
				legal_k = 1'b0;
		endcase
	endfunction

	always_comb
	begin
		bad_k = i_wr && i_k && !legal_k(i_data);
		take  = i_wr && (!o_full || i_req); // slot frees up this cycle

		wr_word = '{k: i_k, data: i_data};
		if (bad_k)
			wr_word = '{k: 1'b1, data: IDLE_K}; // illegal K becomes idle
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_rst)
		begin
			o_full    <= 1'b0;
			o_overrun <= 1'b0;
			o_k_err   <= 1'b0;
		end
		else
		begin
			o_overrun <= i_wr && !take;
			o_k_err   <= bad_k;
			if (take)
				o_full <= 1'b1;
			else if (i_req)
				o_full <= 1'b0;
		end
	end

	// held byte goes out on request, otherwise the idle comma
	always_ff @(posedge i_CLK)
	begin
		if (take)
			held <= wr_word;
		if (i_req)
			o_word <= o_full ? held : '{k: 1'b1, data: IDLE_K};
	end

endmodule

/* src/link_tx_pkg.sv */
package link_tx_pkg;

	import line_code_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// transmit link types
	////////////////////////////////////////////////////////////////////////////

	// one item handed from intake to encoder
	typedef struct packed {
		logic  k;    // control code flag
		byte_t data;
	} tx_word_t;

	// bits per symbol on the wire
	localparam int unsigned SYM_BITS = $bits(symbol_t);

	typedef logic [3:0] bit_cnt_t; // position inside a symbol, 0 to 9

	typedef enum logic {
		SER_RESET, // no symbol loaded yet, line held low
		SER_RUN
	} ser_state_e;

endpackage

/* src/line_code_pkg.sv */
package line_code_pkg;

	////////////////////////////////////////////////////////////////////////////
	// 8b/10b line code types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [7:0] byte_t;   // HGF EDCBA
	typedef logic [9:0] symbol_t; // bit 0 is a and goes out first, bit 9 is j
	typedef logic       rd_t;     // running disparity

	localparam rd_t RD_NEG = 1'b0;
	localparam rd_t RD_POS = 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// the twelve legal control codes
	////////////////////////////////////////////////////////////////////////////

	localparam byte_t K28_0_BYTE = 8'h1C;
	localparam byte_t K28_1_BYTE = 8'h3C; // comma
	localparam byte_t K28_2_BYTE = 8'h5C;
	localparam byte_t K28_3_BYTE = 8'h7C;
	localparam byte_t K28_4_BYTE = 8'h9C;
	localparam byte_t K28_5_BYTE = 8'hBC; // comma, default idle
	localparam byte_t K28_6_BYTE = 8'hDC;
	localparam byte_t K28_7_BYTE = 8'hFC; // comma

	// x.7 forms, all sent with the 1000/0111 ending
	localparam byte_t K23_7_BYTE = 8'hF7;
	localparam byte_t K27_7_BYTE = 8'hFB;
	localparam byte_t K29_7_BYTE = 8'hFD;
	localparam byte_t K30_7_BYTE = 8'hFE;

endpackage
